// File: Makefile
# Verilator build and run of the ooo_core testbench

VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= ooo_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the output for the pass message"
	@echo "  clean  remove build outputs"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: ooo_core.f
+incdir+rtl
rtl/rename_pkg.sv
rtl/rob_pkg.sv
rtl/rename_stage.sv
rtl/rob.sv
rtl/exec_unit.sv
rtl/retire_map.sv
rtl/ooo_core.sv
test/ooo_core_tb.sv

// File: rtl/exec_unit.sv
////////////////////
// execute stage
// latency countdown slots, out-of-order completion
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defs.svh"

module exec_unit (
    input  wire                    clock,
    input  wire                    rst,
    input  wire                    dispatch,
    input  wire rob_pkg::rob_idx_t tail,          // rob slot of the new instr
    input  wire rob_pkg::lat_t     in_lat,
    input  wire                    in_mispred,
    input  wire                    flush,
    output logic                   exec_busy,     // no free slot
    output logic                   done,
    output rob_pkg::rob_idx_t      done_idx,
    output logic                   done_mispred
);

    logic [`EXEC_SLOTS-1:0] busy;
    logic [`EXEC_SLOTS-1:0] ready;        // count ran out
    logic [`EXEC_SLOTS-1:0] done_hot;     // lowest ready slot
    logic [`EXEC_SLOTS-1:0] free_hot;     // lowest idle slot
    rob_pkg::rob_idx_t      slot_idx [`EXEC_SLOTS];
    rob_pkg::lat_t          slot_cnt [`EXEC_SLOTS];
    logic [`EXEC_SLOTS-1:0] slot_mis;

    always_comb begin
        for (int i = 0; i < `EXEC_SLOTS; i++) begin
            ready[i] = busy[i] && (slot_cnt[i] <= 1);
        end
    end

    assign done_hot  = ready & (~ready + 1'b1);     // isolate lowest set bit
    assign free_hot  = ~busy & (busy + 1'b1);       // lowest clear bit
    assign exec_busy = &busy;
    assign done      = |ready;

    // one-hot select of the finishing slot
    always_comb begin
        done_idx     = '0;
        done_mispred = 1'b0;
        for (int i = 0; i < `EXEC_SLOTS; i++) begin
            if (done_hot[i]) begin
                done_idx     = slot_idx[i];
                done_mispred = slot_mis[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < `EXEC_SLOTS; i++) begin
                if (dispatch && free_hot[i]) begin
                    busy[i] <= 1'b1;
                end else if (done_hot[i]) begin
                    busy[i] <= 1'b0;            // losers stay ready, retry next cycle
                end
            end
        end
    end

    // load on dispatch, count down while busy
    always_ff @(posedge clock) begin
        for (int i = 0; i < `EXEC_SLOTS; i++) begin
            if (dispatch && free_hot[i]) begin
                slot_idx[i] <= tail;
                slot_cnt[i] <= in_lat;
                slot_mis[i] <= in_mispred;
            end else if (busy[i] && slot_cnt[i] > 1) begin
                slot_cnt[i] <= slot_cnt[i] - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/ooo_core.sv
////////////////////
// top level of the back end
// rename, rob, execute, retire
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defs.svh"

module ooo_core (
    input  wire                    clock,
    input  wire                    rst,
    input  wire                    in_valid,
    input  wire rename_pkg::pc_t   in_pc,
    input  wire rename_pkg::areg_t in_areg,
    input  wire rob_pkg::lat_t     in_lat,
    input  wire                    in_mispred,
    output logic                   stall,
    output logic                   commit_valid,
    output rename_pkg::pc_t        commit_pc,
    output rename_pkg::areg_t      commit_areg,
    output rename_pkg::preg_t      commit_preg,
    output logic                   flush
);

    logic                                     dispatch;
    rename_pkg::preg_t                        dispatch_preg;
    rob_pkg::rob_idx_t                        tail;
    logic                                     full;
    rob_pkg::rob_state_t                      rob_state;
    logic                                     exec_busy;
    logic                                     done;
    rob_pkg::rob_idx_t                        done_idx;
    logic                                     done_mispred;
    logic                                     free_valid;     // retire -> rename
    rename_pkg::preg_t                        free_preg;
    rename_pkg::preg_t [(1 << `AREG_LEN)-1:0] rrat_map;
    logic [`PRF_SIZE-1:0]                     used_mask;

    rename_stage rename0 (
        .clock, .rst, .in_valid, .in_areg, .full, .exec_busy, .rob_state,
        .free_valid, .free_preg, .flush, .rrat_map, .used_mask,
        .stall, .dispatch, .dispatch_preg
    );

    rob rob0 (
        .clock, .rst, .dispatch, .in_pc, .in_areg, .dispatch_preg,
        .done, .done_idx, .done_mispred, .tail, .full, .rob_state,
        .commit_valid, .commit_pc, .commit_areg, .commit_preg, .flush
    );

    exec_unit exec0 (
        .clock, .rst, .dispatch, .tail, .in_lat, .in_mispred, .flush,
        .exec_busy, .done, .done_idx, .done_mispred
    );

    retire_map retire0 (
        .clock, .rst, .commit_valid, .commit_areg, .commit_preg,
        .free_valid, .free_preg, .rrat_map, .used_mask
    );

endmodule

`default_nettype wire

// File: rtl/ooo_defs.svh
////////////////////
// sizes for the out-of-order back end
// pc width, register index widths, buffer depth, latency, execute slots
////////////////////

`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

`define XLEN       32   // pc width
`define AREG_LEN   5    // 32 architectural regs
`define PRF_LEN    6    // physical reg index width
`define PRF_SIZE   64   // physical reg count
`define ROB_LEN    3    // rob index width
`define ROB_SIZE   8    // rob depth, power of two
`define LAT_LEN    3    // latency 1..7
`define EXEC_SLOTS 4    // countdown slots in execute

`endif

// File: rtl/rename_pkg.sv
////////////////////
// register and pc types used by rename and retire
////////////////////

`default_nettype none

`include "ooo_defs.svh"

package rename_pkg;

    // program counter
    typedef logic [`XLEN-1:0] pc_t;

    // architectural reg, 0 means no destination
    typedef logic [`AREG_LEN-1:0] areg_t;

    // physical reg
    typedef logic [`PRF_LEN-1:0] preg_t;

endpackage

`default_nettype wire

// File: rtl/rename_stage.sv
////////////////////
// rename stage
// free list, speculative map table, dispatch control
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defs.svh"

module rename_stage (
    input  wire                                      clock,
    input  wire                                      rst,
    input  wire                                      in_valid,
    input  wire rename_pkg::areg_t                   in_areg,
    input  wire                                      full,
    input  wire                                      exec_busy,
    input  wire rob_pkg::rob_state_t                 rob_state,
    input  wire                                      free_valid,   // from retire
    input  wire rename_pkg::preg_t                   free_preg,
    input  wire                                      flush,
    input  wire rename_pkg::preg_t [(1 << `AREG_LEN)-1:0] rrat_map,
    input  wire [`PRF_SIZE-1:0]                      used_mask,
    output logic                                     stall,
    output logic                                     dispatch,
    output rename_pkg::preg_t                        dispatch_preg
);

    localparam int AREG_NUM = 1 << `AREG_LEN;

    logic [`PRF_SIZE-1:0] free_list;        // 1 = free
    rename_pkg::preg_t    spec_map [AREG_NUM];
    rename_pkg::preg_t    alloc_preg;       // lowest free reg
    logic                 need_preg;        // instr has a destination

    assign need_preg = (in_areg != '0);

    assign stall = full | (free_list == '0) | exec_busy
                 | (rob_state == rob_pkg::rob_recover);

    assign dispatch = in_valid & ~stall;    // strobes under stall dropped

    // no destination -> keep current mapping, nothing allocated
    assign dispatch_preg = need_preg ? alloc_preg : spec_map[in_areg];

    // priority pick, lowest index wins
    always_comb begin
        alloc_preg = '0;
        for (int i = `PRF_SIZE - 1; i >= 0; i--) begin
            if (free_list[i]) begin
                alloc_preg = rename_pkg::preg_t'(i);
            end
        end
    end

    ////////////////////
    // map and free list update
    ////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `PRF_SIZE; i++) begin
                free_list[i] <= (i >= AREG_NUM);    // identity mapping holds the low regs
            end
            for (int i = 0; i < AREG_NUM; i++) begin
                spec_map[i] <= rename_pkg::preg_t'(i);
            end
        end else if (flush) begin
            // roll back to committed state
            free_list <= ~used_mask;
            for (int i = 0; i < AREG_NUM; i++) begin
                spec_map[i] <= rrat_map[i];
            end
        end else begin
            if (free_valid) begin
                free_list[free_preg] <= 1'b1;       // overwritten by commit
            end
            if (dispatch && need_preg) begin
                free_list[alloc_preg] <= 1'b0;
                spec_map[in_areg]     <= alloc_preg;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/retire_map.sv
////////////////////
// retirement map table
// frees overwritten regs, tracks mapped regs for flush
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defs.svh"

module retire_map (
    input  wire                                  clock,
    input  wire                                  rst,
    input  wire                                  commit_valid,
    input  wire rename_pkg::areg_t               commit_areg,
    input  wire rename_pkg::preg_t               commit_preg,
    output logic                                 free_valid,
    output rename_pkg::preg_t                    free_preg,    // previous mapping
    output rename_pkg::preg_t [(1 << `AREG_LEN)-1:0] rrat_map, // includes this commit
    output logic [`PRF_SIZE-1:0]                 used_mask
);

    localparam int AREG_NUM = 1 << `AREG_LEN;

    rename_pkg::preg_t [AREG_NUM-1:0] map_q;
    logic [`PRF_SIZE-1:0]             used_q;
    logic                             wr;       // commit with a destination

    assign wr         = commit_valid & (commit_areg != '0);
    assign free_valid = wr;
    assign free_preg  = map_q[commit_areg];

    // next table, so a flush sees the mispredicted instr's own commit
    always_comb begin
        rrat_map  = map_q;
        used_mask = used_q;
        if (wr) begin
            rrat_map[commit_areg]  = commit_preg;
            used_mask[free_preg]   = 1'b0;
            used_mask[commit_preg] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < AREG_NUM; i++) begin
                map_q[i] <= rename_pkg::preg_t'(i);     // areg i -> preg i
            end
            for (int j = 0; j < `PRF_SIZE; j++) begin
                used_q[j] <= (j < AREG_NUM);
            end
        end else begin
            map_q  <= rrat_map;
            used_q <= used_mask;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rob.sv
////////////////////
// reorder buffer
// in-order dispatch and commit, out-of-order completion, flush
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defs.svh"

module rob (
    input  wire                        clock,
    input  wire                        rst,
    input  wire                        dispatch,
    input  wire rename_pkg::pc_t       in_pc,
    input  wire rename_pkg::areg_t     in_areg,
    input  wire rename_pkg::preg_t     dispatch_preg,
    input  wire                        done,          // from execute
    input  wire rob_pkg::rob_idx_t     done_idx,
    input  wire                        done_mispred,
    output rob_pkg::rob_idx_t          tail,          // slot of next dispatch
    output logic                       full,
    output rob_pkg::rob_state_t        rob_state,
    output logic                       commit_valid,
    output rename_pkg::pc_t            commit_pc,
    output rename_pkg::areg_t          commit_areg,
    output rename_pkg::preg_t          commit_preg,
    output logic                       flush
);

    rob_pkg::rob_idx_t    head;
    logic [`ROB_LEN:0]    count;              // one extra bit, 0..ROB_SIZE

    // entry payload
    rename_pkg::pc_t      ent_pc   [`ROB_SIZE];
    rename_pkg::areg_t    ent_areg [`ROB_SIZE];
    rename_pkg::preg_t    ent_preg [`ROB_SIZE];
    logic [`ROB_SIZE-1:0] ent_done;           // executed flag
    logic [`ROB_SIZE-1:0] ent_mis;            // mispredict flag

    assign full = (count == `ROB_SIZE);

    // head retires once executed
    assign commit_valid = (count != '0) & ent_done[head];
    assign commit_pc    = ent_pc[head];
    assign commit_areg  = ent_areg[head];
    assign commit_preg  = ent_preg[head];

    // mispredict at head flushes everything younger
    assign flush = commit_valid & ent_mis[head];

    ////////////////////
    // pointers, flags, state
    ////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_done  <= '0;
            rob_state <= rob_pkg::rob_run;
        end else if (flush) begin
            head      <= '0;              // buffer empties in one edge
            tail      <= '0;
            count     <= '0;
            rob_state <= rob_pkg::rob_recover;
        end else begin
            rob_state <= rob_pkg::rob_run;
            if (dispatch) begin
                ent_done[tail] <= 1'b0;
                ent_mis[tail]  <= 1'b0;
                tail           <= tail + 1'b1;    // wraps at ROB_SIZE
            end
            if (done) begin
                ent_done[done_idx] <= 1'b1;
                ent_mis[done_idx]  <= done_mispred;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            count <= count + (`ROB_LEN+1)'(dispatch) - (`ROB_LEN+1)'(commit_valid);
        end
    end

    // payload written at tail
    always_ff @(posedge clock) begin
        if (dispatch) begin
            ent_pc[tail]   <= in_pc;
            ent_areg[tail] <= in_areg;
            ent_preg[tail] <= dispatch_preg;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rob_pkg.sv
////////////////////
// reorder buffer types
// slot index, latency, buffer state
////////////////////

`default_nettype none

`include "ooo_defs.svh"

package rob_pkg;

    // slot number in the circular buffer
    typedef logic [`ROB_LEN-1:0] rob_idx_t;

    // execution latency, 1 to 7 cycles
    typedef logic [`LAT_LEN-1:0] lat_t;

    // rob_recover lasts one cycle after a flush
    typedef enum logic {
        rob_run,
        rob_recover
    } rob_state_t;

endpackage

`default_nettype wire

// File: test/ooo_core_tb.sv
////////////////////
// testbench for the out-of-order back end
// golden-file stimulus, commit order and map checks, timeout
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defs.svh"

module ooo_core_tb;

    localparam int          AREG_NUM = 1 << `AREG_LEN;
    localparam int          LONG_RUN = 8;          // leading long-latency lines
    localparam logic [31:0] END_PC   = 32'hffff_ffff;
    localparam string       GOLDEN   = "test/ooo_golden.dat";

    logic                clock;
    logic                rst;
    logic                in_valid;
    rename_pkg::pc_t     in_pc;
    rename_pkg::areg_t   in_areg;
    rob_pkg::lat_t       in_lat;
    logic                in_mispred;
    logic                stall;
    logic                commit_valid;
    rename_pkg::pc_t     commit_pc;
    rename_pkg::areg_t   commit_areg;
    rename_pkg::preg_t   commit_preg;
    logic                flush;

    // golden lines, one entry per instruction
    rename_pkg::pc_t     g_pc    [$];
    rename_pkg::areg_t   g_areg  [$];
    rob_pkg::lat_t       g_lat   [$];
    logic                g_mis   [$];
    logic                g_wrong [$];

    int                  exp_q [$];                // line numbers still to commit
    rename_pkg::preg_t   model_map [AREG_NUM];     // retirement map model
    int                  cycles;
    int                  cycle_limit;
    logic                stall_seen;               // stall during the long run

    ooo_core dut0 (
        .clock, .rst, .in_valid, .in_pc, .in_areg, .in_lat, .in_mispred,
        .stall, .commit_valid, .commit_pc, .commit_areg, .commit_preg, .flush
    );

    always #5 clock = ~clock;   // 10 ns period

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("ERR %0t: %s", $time, msg));
    endtask

    ////////////////////
    // golden file
    ////////////////////

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] pc, a, l, m, w;
        logic        got_end;
        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            abort_run("cannot open the golden file");
        end
        got_end = 1'b0;
        while (!got_end && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == 8'h2f) begin
                continue;                       // blank or comment line
            end
            n = $sscanf(line, "%h %h %h %h %h", pc, a, l, m, w);
            if (n != 5) begin
                abort_run($sformatf("bad line in golden file: %s", line));
            end
            if (pc == END_PC) begin
                got_end = 1'b1;
            end else begin
                g_pc.push_back(pc);
                g_areg.push_back(rename_pkg::areg_t'(a));
                g_lat.push_back(rob_pkg::lat_t'(l));
                g_mis.push_back(m[0]);
                g_wrong.push_back(w[0]);
                if (!w[0]) begin
                    exp_q.push_back(g_pc.size() - 1);   // only right-path lines commit
                end
            end
        end
        $fclose(fd);
        if (!got_end) begin
            abort_run("golden file has no end marker");
        end
    endtask

    task automatic drive_line(input int i);
        in_valid   = 1'b1;
        in_pc      = g_pc[i];
        in_areg    = g_areg[i];
        in_lat     = g_lat[i];
        in_mispred = g_mis[i];
    endtask

    ////////////////////
    // commit checks
    ////////////////////

    task automatic check_commit();
        int e;
        assert (exp_q.size() > 0)
            else report_mismatch($sformatf("unexpected commit pc %h", commit_pc));
        e = exp_q.pop_front();
        assert (commit_pc == g_pc[e])
            else report_mismatch($sformatf("commit pc %h, expected %h", commit_pc, g_pc[e]));
        assert (commit_areg == g_areg[e])
            else report_mismatch($sformatf("commit areg %0d, expected %0d",
                                           commit_areg, g_areg[e]));
        assert (flush == g_mis[e])
            else report_mismatch($sformatf("flush %b at pc %h, expected %b",
                                           flush, commit_pc, g_mis[e]));
        for (int k = 0; k < AREG_NUM; k++) begin
            if (k != int'(commit_areg)) begin
                assert (model_map[k] != commit_preg)
                    else report_mismatch($sformatf("preg %0d committed, still held by areg %0d",
                                                   commit_preg, k));
            end
        end
        if (commit_areg != '0) begin
            model_map[commit_areg] = commit_preg;
        end
    endtask

    // outputs sampled mid-cycle
    always @(negedge clock) begin
        if (!rst) begin
            assert (!flush || commit_valid)
                else report_mismatch("flush without a commit");
            if (commit_valid) begin
                check_commit();
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("run did not finish within %0d cycles, %0d commits missing",
                                cycle_limit, exp_q.size()));
        end
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int   idx;
        logic redirect;     // mispredict sent, wait for flush
        logic skip_wrong;
        clock       = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_pc       = '0;
        in_areg     = '0;
        in_lat      = '0;
        in_mispred  = 1'b0;
        cycles      = 0;
        cycle_limit = 1000;
        stall_seen  = 1'b0;
        for (int k = 0; k < AREG_NUM; k++) begin
            model_map[k] = rename_pkg::preg_t'(k);  // identity after reset
        end
        load_golden();
        cycle_limit = g_pc.size() * 16 + 100;
        repeat (3) @(posedge clock);
        #1 rst = 1'b0;
        idx        = 0;
        redirect   = 1'b0;
        skip_wrong = 1'b0;
        while (idx < g_pc.size()) begin
            @(posedge clock);
            #1;
            if (flush) begin
                in_valid   = 1'b0;              // strobe would vanish in the flush edge
                redirect   = 1'b0;
                skip_wrong = 1'b1;
            end else begin
                if (skip_wrong) begin
                    while (idx < g_pc.size() && g_wrong[idx]) begin
                        idx++;                  // wrong path, never fetched again
                    end
                    skip_wrong = 1'b0;
                end
                if (idx < LONG_RUN && stall) begin
                    stall_seen = 1'b1;
                end
                if (idx < g_pc.size() && !stall && !(redirect && !g_wrong[idx])) begin
                    drive_line(idx);
                    if (g_mis[idx]) begin
                        redirect = 1'b1;
                    end
                    idx++;
                end else begin
                    in_valid = 1'b0;
                end
            end
        end
        @(posedge clock);
        #1 in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clock);
        end
        repeat (20) @(posedge clock);   // any stray commit trips the monitor
        if (!stall_seen) begin
            abort_run("stall never rose during the long-latency run");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: test/ooo_golden.dat
// columns in hex: pc areg latency mispredict wrong_path
// last line is the end marker with pc ffffffff
00001000 01 7 0 0
00001004 02 7 0 0
00001008 03 7 0 0
0000100c 04 7 0 0
00001010 05 7 0 0
00001014 06 7 0 0
00001018 07 7 0 0
0000101c 08 7 0 0
00001020 09 6 0 0
00001024 0a 1 0 0
00001028 0b 3 0 0
0000102c 01 1 0 0
00001030 03 4 1 0
00001034 02 1 0 1
00001038 04 2 0 1
0000103c 05 1 0 1
00002000 01 2 0 0
00002004 00 1 0 0
00002008 06 1 1 0
0000200c 07 1 0 1
00002010 02 3 0 1
00003000 07 3 0 0
ffffffff 00 0 0 0
